// File: src/z80Pkg.sv
package z80Pkg;

// address space and instruction sizes
localparam int AddrWidth = 16;
localparam int MaxInsnLen = 4;
localparam int InsnBits = MaxInsnLen * 8;
localparam int LenWidth = 3;

// first fetch address out of reset
localparam logic [AddrWidth-1:0] ResetPc = 16'h0000;

// apb master phases
typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
} apbPhaseE;

// instruction groups reported by the decoder
typedef enum logic [7:0] {
    // unprefixed, one byte plus operands
    NOP, LD_DD_NN, LD_IND_BCDE_A, INC_DEC_DD,
    INC_DEC_REG, RR_RLCA, ADD_HL_DD, DAA,
    CPL, INC_DEC_IND_HL, LD_A_IND_BCDE, LD_REG_N,
    LD_IND_NN_HL, LD_HL_IND_NN, LD_IND_HL_N, LD_REG_REG,
    LD_IND_NN_A, SCF, LD_A_IND_NN, CCF,
    LD_IND_HL_REG, HALT, POP_QQ, PUSH_QQ,
    EX_AF_AF2, EX_IND_SP_HL, EX_DE_HL, EXX,
    LD_SP_HL, ALU_A_REG, ALU_A_IND_HL, ALU_A_N,
    EI_DI,
    // cb prefix
    RR_RLC_REG,
    // ed prefix
    ADC_SBC_HL_DD, LD_DD_IND_NN, NEG, LD_IND_NN_DD,
    LD_I_A, LD_R_A, LD_A_I, LD_A_R,
    // ed block transfer and search
    LDI, CPI, LDD, CPD,
    LDIR, CPIR, LDDR, CPDR,
    // dd and fd indexed
    ADD_IXIY_SS, INC_DEC_IXIY, LD_REG_IDX_IXIY, LD_IDX_IXIY_REG,
    LD_IXIY_NN, LD_IXIY_IND_NN, INC_DEC_IDX_IXIY, LD_IDX_IXIY_N,
    EX_IND_SP_IXIY, POP_IXIY, PUSH_IXIY, LD_IND_NN_IXIY,
    ALU_A_IDX_IXIY, LD_SP_IXIY,
    // decoder status
    NEED_MORE_BYTES,
    ILLEGAL_INSTR
} insnGroupE;

endpackage

// File: src/instrDecoder.sv
module instrDecoder import z80Pkg::*; (
    input  logic [InsnBits-1:0] collected,
    input  logic [1:0]          opLen,
    output logic [LenWidth-1:0] len,
    output insnGroupE           group
);

logic [7:0] b0;
logic [7:0] b1;

// little endian, prefix sits in the low byte
assign b0 = collected[7:0];
assign b1 = collected[15:8];

always_comb begin
    group = ILLEGAL_INSTR;
    len = 3'd1;
    if (opLen == 2'd0) begin
        group = NEED_MORE_BYTES;
    end else if (opLen == 2'd1) begin
        case (b0[7:6])
            2'b00: begin
                case (b0[2:0])
                    3'd0: begin
                        // jumps and djnz are not handled here
                        if (b0 == 8'h00) begin
                            group = NOP;
                        end else if (b0 == 8'h08) begin
                            group = EX_AF_AF2;
                        end
                    end
                    3'd1: begin
                        group = b0[3] ? ADD_HL_DD : LD_DD_NN;
                        len = b0[3] ? 3'd1 : 3'd3;
                    end
                    3'd2: begin
                        // upper half carries a 16-bit address
                        len = b0[5] ? 3'd3 : 3'd1;
                        case (b0[5:3])
                            3'd0, 3'd2: group = LD_IND_BCDE_A;
                            3'd1, 3'd3: group = LD_A_IND_BCDE;
                            3'd4: group = LD_IND_NN_HL;
                            3'd5: group = LD_HL_IND_NN;
                            3'd6: group = LD_IND_NN_A;
                            default: group = LD_A_IND_NN;
                        endcase
                    end
                    3'd3: group = INC_DEC_DD;
                    3'd4, 3'd5: group = (b0[5:3] == 3'd6) ? INC_DEC_IND_HL : INC_DEC_REG;
                    3'd6: begin
                        group = (b0[5:3] == 3'd6) ? LD_IND_HL_N : LD_REG_N;
                        len = 3'd2;
                    end
                    default: begin
                        case (b0[5:3])
                            3'd4: group = DAA;
                            3'd5: group = CPL;
                            3'd6: group = SCF;
                            3'd7: group = CCF;
                            default: group = RR_RLCA;
                        endcase
                    end
                endcase
            end
            2'b01: begin
                // ld r,(hl) is absent from the table
                if (b0 == 8'h76) begin
                    group = HALT;
                end else if (b0[5:3] == 3'd6) begin
                    group = LD_IND_HL_REG;
                end else if (b0[2:0] != 3'd6) begin
                    group = LD_REG_REG;
                end
            end
            2'b10: group = (b0[2:0] == 3'd6) ? ALU_A_IND_HL : ALU_A_REG;
            default: begin
                case (b0)
                    8'hC1, 8'hD1, 8'hE1, 8'hF1: group = POP_QQ;
                    8'hC5, 8'hD5, 8'hE5, 8'hF5: group = PUSH_QQ;
                    8'hE3: group = EX_IND_SP_HL;
                    8'hEB: group = EX_DE_HL;
                    8'hD9: group = EXX;
                    8'hF9: group = LD_SP_HL;
                    8'hF3, 8'hFB: group = EI_DI;
                    8'hCB, 8'hDD, 8'hED, 8'hFD: begin
                        group = NEED_MORE_BYTES;
                        len = 3'd2;
                    end
                    default: begin
                        if (b0[2:0] == 3'd6) begin
                            group = ALU_A_N;
                            len = 3'd2;
                        end
                    end
                endcase
            end
        endcase
    end else begin
        len = 3'd2;
        case (b0)
            8'hCB: begin
                // rotates only, (hl) forms excluded
                if (b1[7:5] == 3'b000 && b1[2:0] != 3'd6) begin
                    group = RR_RLC_REG;
                end
            end
            8'hED: begin
                case (b1)
                    8'h44: group = NEG;
                    8'h47: group = LD_I_A;
                    8'h4F: group = LD_R_A;
                    8'h57: group = LD_A_I;
                    8'h5F: group = LD_A_R;
                    8'hA0: group = LDI;
                    8'hA1: group = CPI;
                    8'hA8: group = LDD;
                    8'hA9: group = CPD;
                    8'hB0: group = LDIR;
                    8'hB1: group = CPIR;
                    8'hB8: group = LDDR;
                    8'hB9: group = CPDR;
                    default: begin
                        if (b1[7:6] == 2'b01 && b1[2:0] == 3'd2) begin
                            group = ADC_SBC_HL_DD;
                        end else if (b1[7:6] == 2'b01 && b1[2:0] == 3'd3) begin
                            group = b1[3] ? LD_DD_IND_NN : LD_IND_NN_DD;
                            len = 3'd4;
                        end
                    end
                endcase
            end
            8'hDD, 8'hFD: begin
                case (b1)
                    8'h09, 8'h19, 8'h29, 8'h39: group = ADD_IXIY_SS;
                    8'h23, 8'h2B: group = INC_DEC_IXIY;
                    8'hE1: group = POP_IXIY;
                    8'hE3: group = EX_IND_SP_IXIY;
                    8'hE5: group = PUSH_IXIY;
                    8'hF9: group = LD_SP_IXIY;
                    8'h21: begin
                        group = LD_IXIY_NN;
                        len = 3'd4;
                    end
                    8'h22: begin
                        group = LD_IND_NN_IXIY;
                        len = 3'd4;
                    end
                    8'h2A: begin
                        group = LD_IXIY_IND_NN;
                        len = 3'd4;
                    end
                    8'h34, 8'h35: begin
                        group = INC_DEC_IDX_IXIY;
                        len = 3'd3;
                    end
                    8'h36: begin
                        group = LD_IDX_IXIY_N;
                        len = 3'd4;
                    end
                    default: begin
                        // displacement byte follows the opcode
                        if (b1[7:6] == 2'b01 && b1 != 8'h76 && b1[2:0] == 3'd6) begin
                            group = LD_REG_IDX_IXIY;
                            len = 3'd3;
                        end else if (b1[7:6] == 2'b01 && b1 != 8'h76 && b1[5:3] == 3'd6) begin
                            group = LD_IDX_IXIY_REG;
                            len = 3'd3;
                        end else if (b1[7:6] == 2'b10 && b1[2:0] == 3'd6) begin
                            group = ALU_A_IDX_IXIY;
                            len = 3'd3;
                        end
                    end
                endcase
            end
            default: group = ILLEGAL_INSTR;
        endcase
    end
end

endmodule

// File: src/apbFetchMaster.sv
module apbFetchMaster import z80Pkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 byteReq,
    input  logic [AddrWidth-1:0] byteAddr,
    output logic                 byteValid,
    output logic [7:0]           byteData,
    output logic [AddrWidth-1:0] paddr,
    output logic                 psel,
    output logic                 penable,
    input  logic [7:0]           prdata,
    input  logic                 pready
);

apbPhaseE phase;
logic     startXfer;
logic     doneXfer;

// hold off while the previous byte is still being handed back
assign startXfer = (phase == IDLE) && byteReq && !byteValid;
assign doneXfer = (phase == ACCESS) && pready;

assign psel = (phase != IDLE);
assign penable = (phase == ACCESS);

always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
        phase <= IDLE;
        byteValid <= 1'b0;
    end else begin
        byteValid <= doneXfer;
        case (phase)
            IDLE: if (startXfer) phase <= SETUP;
            SETUP: phase <= ACCESS;
            ACCESS: if (pready) phase <= IDLE;
            default: phase <= IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (startXfer) begin
        paddr <= byteAddr;
    end
    if (doneXfer) begin
        byteData <= prdata;
    end
end

// access only while the assembler still requests this address
penableNeedsPsel: assert property (@(posedge clk) disable iff (!arstN)
    penable |-> psel && byteReq && (byteAddr == paddr));

// address frozen from setup until pready closes the access
paddrHeld: assert property (@(posedge clk) disable iff (!arstN)
    (phase == SETUP || (phase == ACCESS && !pready)) |=> $stable(paddr));

endmodule

// File: src/instrAssembler.sv
module instrAssembler import z80Pkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 byteValid,
    input  logic [7:0]           byteData,
    input  logic [LenWidth-1:0]  len,
    input  insnGroupE            group,
    input  logic                 insnReady,
    output logic                 byteReq,
    output logic [AddrWidth-1:0] byteAddr,
    output logic [InsnBits-1:0]  collected,
    output logic [1:0]           opLen,
    output logic                 insnValid,
    output logic [InsnBits-1:0]  insnBytes,
    output logic [LenWidth-1:0]  insnLen,
    output insnGroupE            insnGroup,
    output logic [AddrWidth-1:0] insnPc
);

logic [LenWidth-1:0]  count;
logic [LenWidth-1:0]  nextCount;
logic [AddrWidth-1:0] pc;
logic [AddrWidth-1:0] startPc;
logic                 complete;
logic                 load;

assign nextCount = count + LenWidth'(1);
assign complete = (group != NEED_MORE_BYTES) && (count == len);
// output slot must have drained before the next instruction moves in
assign load = complete && !insnValid;

// decoder len is always ahead of count until the instruction is whole
assign byteReq = (count < len);
assign byteAddr = pc;

always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
        count <= '0;
        opLen <= '0;
        pc <= ResetPc;
        startPc <= ResetPc;
        collected <= '0;
        insnValid <= 1'b0;
    end else begin
        if (insnValid && insnReady) begin
            insnValid <= 1'b0;
        end
        if (load) begin
            insnValid <= 1'b1;
            count <= '0;
            opLen <= '0;
            collected <= '0;
            startPc <= pc;
        end else if (byteValid) begin
            collected[8*count[1:0] +: 8] <= byteData;
            count <= nextCount;
            pc <= pc + AddrWidth'(1);
            // all opcode bytes in, let the decoder look at the longer opcode
            if (group == NEED_MORE_BYTES && nextCount == len) begin
                opLen <= nextCount[1:0];
            end
        end
    end
end

always_ff @(posedge clk) begin
    if (load) begin
        insnBytes <= collected;
        insnLen <= len;
        insnGroup <= group;
        insnPc <= startPc;
    end
end

insnHeld: assert property (@(posedge clk) disable iff (!arstN)
    insnValid && !insnReady |=> insnValid && $stable(insnBytes) && $stable(insnLen)
        && $stable(insnGroup) && $stable(insnPc));

insnLenRange: assert property (@(posedge clk) disable iff (!arstN)
    insnValid |-> (insnLen >= 1) && (insnLen <= MaxInsnLen));

endmodule

// File: src/z80Fetch.sv
module z80Fetch import z80Pkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    output logic [AddrWidth-1:0] paddr,
    output logic                 psel,
    output logic                 penable,
    input  logic [7:0]           prdata,
    input  logic                 pready,
    output logic                 insnValid,
    input  logic                 insnReady,
    output logic [InsnBits-1:0]  insnBytes,
    output logic [LenWidth-1:0]  insnLen,
    output insnGroupE            insnGroup,
    output logic [AddrWidth-1:0] insnPc
);

logic                 byteReq;
logic [AddrWidth-1:0] byteAddr;
logic                 byteValid;
logic [7:0]           byteData;
logic [InsnBits-1:0]  collected;
logic [1:0]           opLen;
logic [LenWidth-1:0]  len;
insnGroupE            group;

instrAssembler assembler (
    .clk, .arstN, .byteValid, .byteData, .len, .group, .insnReady,
    .byteReq, .byteAddr, .collected, .opLen,
    .insnValid, .insnBytes, .insnLen, .insnGroup, .insnPc
);

instrDecoder decoder (
    .collected, .opLen, .len, .group
);

apbFetchMaster fetchMaster (
    .clk, .arstN, .byteReq, .byteAddr, .byteValid, .byteData,
    .paddr, .psel, .penable, .prdata, .pready
);

endmodule

// File: dv/progMemApb.sv
module progMemApb import z80Pkg::*; (
    input  logic [AddrWidth-1:0] paddr,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 waitState,
    output logic [7:0]           prdata,
    output logic                 pready
);

timeunit 1ns;
timeprecision 100ps;

// program bytes, loaded by the testbench before reset is released
logic [7:0] mem [256];

// low address byte picks the location, upper bits alias
assign prdata = mem[paddr[7:0]];

// every access cycle with waitState high adds one wait state
assign pready = psel && penable && !waitState;

endmodule

// File: dv/z80FetchTb.sv
module z80FetchTb import z80Pkg::*;;

timeunit 1ns;
timeprecision 100ps;

typedef struct packed {
    logic [0:MaxInsnLen-1][7:0] ops;
    insnGroupE                  group;
    logic [LenWidth-1:0]        len;
} progRowT;

localparam int NumRows = 30;
localparam int WaitLimit = 500;

logic                 clk = 1'b0;
logic                 arstN = 1'b0;
logic                 waitState = 1'b0;
logic                 insnReady = 1'b0;
logic [AddrWidth-1:0] paddr;
logic                 psel;
logic                 penable;
logic [7:0]           prdata;
logic                 pready;
logic                 insnValid;
logic [InsnBits-1:0]  insnBytes;
logic [LenWidth-1:0]  insnLen;
insnGroupE            insnGroup;
logic [AddrWidth-1:0] insnPc;
logic [15:0]          lfsrState = 16'd49;
logic [AddrWidth-1:0] expAddr = ResetPc;
int                   checkCount = 0;
int                   errorCount = 0;

// opcode and operand bytes in fetch order, then expected group and length
progRowT rows [NumRows] = '{
    '{{8'h00, 8'h00, 8'h00, 8'h00}, NOP, 3'd1},
    '{{8'h41, 8'h00, 8'h00, 8'h00}, LD_REG_REG, 3'd1},
    '{{8'h80, 8'h00, 8'h00, 8'h00}, ALU_A_REG, 3'd1},
    '{{8'h76, 8'h00, 8'h00, 8'h00}, HALT, 3'd1},
    '{{8'hD9, 8'h00, 8'h00, 8'h00}, EXX, 3'd1},
    '{{8'h21, 8'h34, 8'h12, 8'h00}, LD_DD_NN, 3'd3},
    '{{8'h06, 8'h55, 8'h00, 8'h00}, LD_REG_N, 3'd2},
    '{{8'hC6, 8'h0F, 8'h00, 8'h00}, ALU_A_N, 3'd2},
    '{{8'h32, 8'h00, 8'h80, 8'h00}, LD_IND_NN_A, 3'd3},
    '{{8'hCB, 8'h00, 8'h00, 8'h00}, RR_RLC_REG, 3'd2},
    '{{8'hCB, 8'h1F, 8'h00, 8'h00}, RR_RLC_REG, 3'd2},
    '{{8'hED, 8'hB0, 8'h00, 8'h00}, LDIR, 3'd2},
    '{{8'hED, 8'hB9, 8'h00, 8'h00}, CPDR, 3'd2},
    '{{8'hED, 8'h47, 8'h00, 8'h00}, LD_I_A, 3'd2},
    '{{8'hED, 8'h5F, 8'h00, 8'h00}, LD_A_R, 3'd2},
    '{{8'hED, 8'h4B, 8'h34, 8'h12}, LD_DD_IND_NN, 3'd4},
    '{{8'hED, 8'h43, 8'h78, 8'h56}, LD_IND_NN_DD, 3'd4},
    '{{8'hDD, 8'h21, 8'hCD, 8'hAB}, LD_IXIY_NN, 3'd4},
    '{{8'hFD, 8'h36, 8'h05, 8'h77}, LD_IDX_IXIY_N, 3'd4},
    '{{8'hDD, 8'h7E, 8'h03, 8'h00}, LD_REG_IDX_IXIY, 3'd3},
    '{{8'hFD, 8'h77, 8'h02, 8'h00}, LD_IDX_IXIY_REG, 3'd3},
    '{{8'hDD, 8'h86, 8'h01, 8'h00}, ALU_A_IDX_IXIY, 3'd3},
    '{{8'hFD, 8'hE5, 8'h00, 8'h00}, PUSH_IXIY, 3'd2},
    '{{8'h10, 8'h00, 8'h00, 8'h00}, ILLEGAL_INSTR, 3'd1},
    '{{8'hC3, 8'h00, 8'h00, 8'h00}, ILLEGAL_INSTR, 3'd1},
    '{{8'hED, 8'h00, 8'h00, 8'h00}, ILLEGAL_INSTR, 3'd2},
    '{{8'hDD, 8'hCB, 8'h00, 8'h00}, ILLEGAL_INSTR, 3'd2},
    '{{8'hCB, 8'h06, 8'h00, 8'h00}, ILLEGAL_INSTR, 3'd2},
    '{{8'hFB, 8'h00, 8'h00, 8'h00}, EI_DI, 3'd1},
    '{{8'h3E, 8'h99, 8'h00, 8'h00}, LD_REG_N, 3'd2}
};

z80Fetch uut (
    .clk, .arstN, .paddr, .psel, .penable, .prdata, .pready,
    .insnValid, .insnReady, .insnBytes, .insnLen, .insnGroup, .insnPc
);

progMemApb progMem (
    .paddr, .psel, .penable, .waitState, .prdata, .pready
);

always #10 clk = ~clk;

// fibonacci lfsr x^16 + x^14 + x^13 + x^11 + 1, one shift per bit
function automatic logic takeBit();
    lfsrState = {lfsrState[14:0],
                 lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10]};
    return lfsrState[0];
endfunction

function automatic logic [7:0] fillByte(int addr);
    return 8'((addr * 37) ^ 8'hC3);
endfunction

// operands little-endian after the opcode, zero above the length
function automatic logic [InsnBits-1:0] packBytes(progRowT row);
    logic [InsnBits-1:0] result;
    result = '0;
    for (int i = 0; i < MaxInsnLen; i++) begin
        if (i < row.len) begin
            result[8*i +: 8] = row.ops[i];
        end
    end
    return result;
endfunction

task automatic loadProgram();
    int addr;
    for (int a = 0; a < 256; a++) begin
        progMem.mem[a] = fillByte(a);
    end
    addr = ResetPc;
    for (int r = 0; r < NumRows; r++) begin
        for (int i = 0; i < rows[r].len; i++) begin
            progMem.mem[addr[7:0]] = rows[r].ops[i];
            addr++;
        end
    end
endtask

task automatic checkGroup(insnGroupE got, insnGroupE exp);
    checkCount++;
    if (got !== exp) begin
        errorCount++;
        $display("[FAIL] insnGroup: got 0x%h (%s), expected 0x%h (%s) at %0t",
                 got, got.name(), exp, exp.name(), $time);
    end
endtask

task automatic checkLen(logic [LenWidth-1:0] got, logic [LenWidth-1:0] exp);
    checkCount++;
    if (got !== exp) begin
        errorCount++;
        $display("[FAIL] insnLen: got 0x%h, expected 0x%h at %0t", got, exp, $time);
    end
endtask

task automatic checkBytes(logic [InsnBits-1:0] got, logic [InsnBits-1:0] exp);
    checkCount++;
    if (got !== exp) begin
        errorCount++;
        $display("[FAIL] insnBytes: got 0x%h, expected 0x%h at %0t", got, exp, $time);
    end
endtask

task automatic checkPc(string name, logic [AddrWidth-1:0] got, logic [AddrWidth-1:0] exp);
    checkCount++;
    if (got !== exp) begin
        errorCount++;
        $display("[FAIL] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
endtask

task automatic checkBit(string name, logic got, logic exp);
    checkCount++;
    if (got !== exp) begin
        errorCount++;
        $display("[FAIL] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
endtask

// random wait states and executor stalls
always @(posedge clk) begin
    #2;
    waitState = takeBit();
    insnReady = takeBit();
end

// every completed read must hit the next address in order
always @(negedge clk) begin
    if (arstN && psel && penable && pready) begin
        checkPc("paddr", paddr, expAddr);
        expAddr = expAddr + AddrWidth'(1);
    end
end

initial begin
    int                   waitCycles;
    logic [AddrWidth-1:0] expPc;

    loadProgram();
    for (int i = 0; i < 16; i++) begin
        @(negedge clk);
        checkBit("psel", psel, 1'b0);
        checkBit("penable", penable, 1'b0);
        checkBit("insnValid", insnValid, 1'b0);
    end
    @(posedge clk);
    #2;
    arstN = 1'b1;
    @(negedge clk);
    checkBit("psel", psel, 1'b0);
    checkBit("penable", penable, 1'b0);
    checkBit("insnValid", insnValid, 1'b0);

    waitCycles = 0;
    while (!psel && waitCycles < WaitLimit) begin
        @(negedge clk);
        waitCycles++;
    end
    if (!psel) begin
        errorCount++;
        $display("no APB setup phase seen after reset was released");
    end else begin
        checkPc("paddr", paddr, ResetPc);
        checkBit("penable", penable, 1'b0);
    end

    expPc = ResetPc;
    for (int r = 0; r < NumRows; r++) begin
        waitCycles = 0;
        @(negedge clk);
        while (!(insnValid && insnReady) && waitCycles < WaitLimit) begin
            @(negedge clk);
            waitCycles++;
        end
        if (!(insnValid && insnReady)) begin
            errorCount++;
            $display("timed out waiting for instruction %0d at pc 0x%h", r, expPc);
            break;
        end
        checkGroup(insnGroup, rows[r].group);
        checkLen(insnLen, rows[r].len);
        checkBytes(insnBytes, packBytes(rows[r]));
        checkPc("insnPc", insnPc, expPc);
        expPc = expPc + AddrWidth'(rows[r].len);
    end

    $display("checks %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0) begin
        $display("Simulation PASSED");
    end else begin
        $display("Simulation FAILED");
    end
    $finish;
end

endmodule

// File: z80Fetch.f
src/z80Pkg.sv
src/instrDecoder.sv
src/apbFetchMaster.sv
src/instrAssembler.sv
src/z80Fetch.sv
dv/progMemApb.sv
dv/z80FetchTb.sv

// File: Bender.yml
package:
  name: z80Fetch

sources:
  - src/z80Pkg.sv
  - src/instrDecoder.sv
  - src/apbFetchMaster.sv
  - src/instrAssembler.sv
  - src/z80Fetch.sv
  - target: test
    files:
      - dv/progMemApb.sv
      - dv/z80FetchTb.sv
